// ==== src.f ====
source/dispatchPkg.sv
source/resourceCheck.sv
source/branchMaskUpdate.sv
source/packetFormer.sv
source/dispatchStage.sv
tb/clockGen.sv
tb/dispatchStageTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the dispatch stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/10ps \
  --top-module dispatchStageTb -f src.f -o simDispatch
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/simDispatch)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "All tests passed"; then
  exit 0
fi
exit 1

// ==== tb/dispatchStageTb.sv ====
// Dispatch stage testbench
// Directed tests for queue capacity stalls, branch-mask clearing and the output register

`timescale 1ns/10ps
`default_nettype none

module dispatchStageTb
  import dispatchPkg::*;
();

  localparam int CLK_PERIOD      = 100;
  localparam int TEST_COUNT      = 5;
  localparam int CYCLES_PER_TEST = 40;

  typedef logic [127:0] chkT;            // Wide enough for any packet

  logic       clk;
  logic       rstN;
  logic       stall;
  logic       renameReady;
  logic       flagRecoverEX;
  logic       ctrlVerified;
  ckptIdT     ctrlVerifiedId;
  renamedPktT renamedPacket [DISPATCH_WIDTH];
  lsqCntT     loadQueueCnt;
  lsqCntT     storeQueueCnt;
  iqCntT      issueQueueCnt;
  alCntT      activeListCnt;

  renamedPktT issueqPacket [DISPATCH_WIDTH];
  alPktT      alPacket [DISPATCH_WIDTH];
  lsqPktT     lsqPacket [DISPATCH_WIDTH];
  logic       dispatchValid;
  ckptMaskT   updatedBranchMask [DISPATCH_WIDTH];
  logic       backEndReady;
  logic       stallFrontEnd;

  // Fields of the group on offer, one entry per lane
  pcT       pcs [DISPATCH_WIDTH];
  logRegT   logDests [DISPATCH_WIDTH];
  physRegT  physDests [DISPATCH_WIDTH];
  physRegT  oldPhysDests [DISPATCH_WIDTH];
  physRegT  src1s [DISPATCH_WIDTH];
  physRegT  src2s [DISPATCH_WIDTH];
  ckptIdT   ckptIds [DISPATCH_WIDTH];
  ckptMaskT masks [DISPATCH_WIDTH];
  logic     loads [DISPATCH_WIDTH];
  logic     stores [DISPATCH_WIDTH];
  logic     destValids [DISPATCH_WIDTH];

  // Packets the back end should hold from the last group taken
  renamedPktT expIq [DISPATCH_WIDTH];
  alPktT      expAl [DISPATCH_WIDTH];
  lsqPktT     expLsq [DISPATCH_WIDTH];

  int seed;
  int errorCount;
  int checkCount;

  clockGen clockGen_inst (
    .clk_o  (clk),
    .rstN_o (rstN)
  );

  dispatchStage dispatchStage_inst (
    .clk                 (clk),
    .rstN_i              (rstN),
    .stall_i             (stall),
    .renameReady_i       (renameReady),
    .flagRecoverEX_i     (flagRecoverEX),
    .ctrlVerified_i      (ctrlVerified),
    .ctrlVerifiedId_i    (ctrlVerifiedId),
    .renamedPacket_i     (renamedPacket),
    .loadQueueCnt_i      (loadQueueCnt),
    .storeQueueCnt_i     (storeQueueCnt),
    .issueQueueCnt_i     (issueQueueCnt),
    .activeListCnt_i     (activeListCnt),
    .issueqPacket_o      (issueqPacket),
    .alPacket_o          (alPacket),
    .lsqPacket_o         (lsqPacket),
    .dispatchValid_o     (dispatchValid),
    .updatedBranchMask_o (updatedBranchMask),
    .backEndReady_o      (backEndReady),
    .stallFrontEnd_o     (stallFrontEnd)
  );

  // Rename field order, MSB first
  function automatic renamedPktT packRenamed(int lane, ckptMaskT mask);
    return {logDests[lane], stores[lane], loads[lane], mask, ckptIds[lane],
            physDests[lane], oldPhysDests[lane], src1s[lane], src2s[lane],
            destValids[lane], pcs[lane]};
  endfunction

  function automatic alPktT packActiveList(int lane);
    return {loads[lane], stores[lane], pcs[lane], logDests[lane], physDests[lane],
            oldPhysDests[lane], destValids[lane]};
  endfunction

  function automatic lsqPktT packLsq(int lane, ckptMaskT mask);
    return {mask, stores[lane], loads[lane]};
  endfunction

  function automatic ckptMaskT clearVerified(ckptMaskT mask, logic verified, ckptIdT id);
    ckptMaskT result;
    result = mask;
    if (verified) begin
      result[id] = 1'b0;                   // Verified checkpoint no longer guards the lane
    end
    return result;
  endfunction

  task automatic checkValue(string name, chkT actual, chkT expected);
    checkCount++;
    if (actual !== expected) begin
      errorCount++;
      $display("Fail at %0t ns: %s is %0h, expected %0h", $time, name, actual, expected);
    end
  endtask

  // Fresh PCs and tags, no memory ops, empty masks
  task automatic randomGroup();
    logic [31:0] r;
    for (int lane = 0; lane < DISPATCH_WIDTH; lane++) begin
      r                  = $random(seed);
      pcs[lane]          = r;
      r                  = $random(seed);
      logDests[lane]     = r[4:0];
      physDests[lane]    = r[10:5];
      oldPhysDests[lane] = r[16:11];
      src1s[lane]        = r[22:17];
      src2s[lane]        = r[28:23];
      destValids[lane]   = r[29];
      ckptIds[lane]      = r[31:30];
      loads[lane]        = 1'b0;
      stores[lane]       = 1'b0;
      masks[lane]        = '0;
    end
  endtask

  // Offer the group for one cycle, then check the ready logic and the registered packets
  task automatic offerGroup(int lq, int sq, int iq, int al, logic holdIn, logic recoverIn,
                            logic verified, ckptIdT verId, logic expectStall);
    logic     expectGo;
    ckptMaskT newMask [DISPATCH_WIDTH];
    expectGo = !expectStall && !holdIn && !recoverIn;
    for (int lane = 0; lane < DISPATCH_WIDTH; lane++) begin
      newMask[lane] = clearVerified(masks[lane], verified, verId);
    end

    @(posedge clk);
    for (int lane = 0; lane < DISPATCH_WIDTH; lane++) begin
      renamedPacket[lane] <= packRenamed(lane, masks[lane]);
    end
    renameReady    <= 1'b1;
    stall          <= holdIn;
    flagRecoverEX  <= recoverIn;
    ctrlVerified   <= verified;
    ctrlVerifiedId <= verId;
    loadQueueCnt   <= lsqCntT'(lq);
    storeQueueCnt  <= lsqCntT'(sq);
    issueQueueCnt  <= iqCntT'(iq);
    activeListCnt  <= alCntT'(al);

    @(negedge clk);
    checkValue("stallFrontEnd_o", chkT'(stallFrontEnd), chkT'(expectStall));
    checkValue("backEndReady_o", chkT'(backEndReady), chkT'(expectGo));
    for (int lane = 0; lane < DISPATCH_WIDTH; lane++) begin
      checkValue($sformatf("updatedBranchMask_o[%0d]", lane),
                 chkT'(updatedBranchMask[lane]), chkT'(newMask[lane]));
    end

    @(posedge clk);                        // Accepting edge when expectGo is set
    renameReady   <= 1'b0;
    stall         <= 1'b0;
    flagRecoverEX <= 1'b0;
    ctrlVerified  <= 1'b0;
    if (expectGo) begin
      for (int lane = 0; lane < DISPATCH_WIDTH; lane++) begin
        expIq[lane]  = packRenamed(lane, newMask[lane]);
        expAl[lane]  = packActiveList(lane);
        expLsq[lane] = packLsq(lane, newMask[lane]);
      end
    end

    @(negedge clk);
    checkValue("dispatchValid_o", chkT'(dispatchValid), chkT'(expectGo));
    for (int lane = 0; lane < DISPATCH_WIDTH; lane++) begin
      checkValue($sformatf("issueqPacket_o[%0d]", lane), chkT'(issueqPacket[lane]),
                 chkT'(expIq[lane]));
      checkValue($sformatf("alPacket_o[%0d]", lane), chkT'(alPacket[lane]),
                 chkT'(expAl[lane]));
      checkValue($sformatf("lsqPacket_o[%0d]", lane), chkT'(lsqPacket[lane]),
                 chkT'(expLsq[lane]));
    end
  endtask

  task automatic resetAndFirstGroup();
    wait (rstN === 1'b1);
    @(negedge clk);
    checkValue("dispatchValid_o", chkT'(dispatchValid), chkT'(1'b0));
    randomGroup();
    loads[1]  = 1'b1;
    stores[2] = 1'b1;
    offerGroup(0, 0, 0, 0, 1'b0, 1'b0, 1'b0, 2'd0, 1'b0);
  endtask

  task automatic loadStoreCapacity();
    randomGroup();
    loads[0] = 1'b1;
    loads[1] = 1'b1;
    loads[3] = 1'b1;
    offerGroup(14, 0, 0, 0, 1'b0, 1'b0, 1'b0, 2'd0, 1'b1);   // 14 + 3 > 16
    randomGroup();
    loads[1] = 1'b1;
    loads[2] = 1'b1;
    offerGroup(14, 0, 0, 0, 1'b0, 1'b0, 1'b0, 2'd0, 1'b0);
    randomGroup();
    stores[0] = 1'b1;
    stores[2] = 1'b1;
    stores[3] = 1'b1;
    offerGroup(0, 14, 0, 0, 1'b0, 1'b0, 1'b0, 2'd0, 1'b1);
    offerGroup(0, 13, 0, 0, 1'b0, 1'b0, 1'b0, 2'd0, 1'b0);   // Fills the store queue
    randomGroup();
    stores[1] = 1'b1;
    stores[3] = 1'b1;
    offerGroup(0, 15, 0, 0, 1'b0, 1'b0, 1'b0, 2'd0, 1'b1);
    offerGroup(0, 14, 0, 0, 1'b0, 1'b0, 1'b0, 2'd0, 1'b0);
  endtask

  task automatic queueCapacity();
    randomGroup();
    offerGroup(0, 0, SIZE_ISSUEQ - 3, 0, 1'b0, 1'b0, 1'b0, 2'd0, 1'b1);
    offerGroup(0, 0, SIZE_ISSUEQ - 4, 0, 1'b0, 1'b0, 1'b0, 2'd0, 1'b0);
    randomGroup();
    offerGroup(0, 0, 0, SIZE_ACTIVELIST - 3, 1'b0, 1'b0, 1'b0, 2'd0, 1'b1);
    offerGroup(0, 0, 0, SIZE_ACTIVELIST - 4, 1'b0, 1'b0, 1'b0, 2'd0, 1'b0);
  endtask

  task automatic branchMaskClearing();
    for (int k = 0; k < CHECKPOINTS; k++) begin
      randomGroup();
      masks[0]  = 4'b1111;
      masks[1]  = 4'b0101;
      masks[2]  = 4'b1010;
      masks[3]  = 4'b1001;
      loads[k]  = 1'b1;                    // LSQ packet carries the mask too
      offerGroup(0, 0, 0, 0, 1'b0, 1'b0, 1'b1, ckptIdT'(k), 1'b0);
    end
    randomGroup();
    masks[0] = 4'b0110;
    masks[2] = 4'b1111;
    offerGroup(0, 0, 0, 0, 1'b0, 1'b0, 1'b0, 2'd2, 1'b0);    // No verification
  endtask

  task automatic blockingInputs();
    randomGroup();
    masks[1] = 4'b1100;
    offerGroup(0, 0, 0, 0, 1'b1, 1'b0, 1'b1, 2'd3, 1'b0);    // Back-end stall
    randomGroup();
    offerGroup(0, 0, 0, 0, 1'b0, 1'b1, 1'b0, 2'd0, 1'b0);    // Recovery
    randomGroup();
    for (int lane = 0; lane < DISPATCH_WIDTH; lane++) begin
      loads[lane] = 1'b1;
    end
    offerGroup(14, 0, 0, 0, 1'b1, 1'b0, 1'b0, 2'd0, 1'b1);
    offerGroup(0, 0, 0, 0, 1'b0, 1'b0, 1'b0, 2'd0, 1'b0);    // Same group, now taken
  endtask

  // Watchdog
  initial begin
    #(TEST_COUNT * CYCLES_PER_TEST * CLK_PERIOD);
    $display("Timeout: tests did not finish within %0d cycles", TEST_COUNT * CYCLES_PER_TEST);
    $display("Some tests failed");
    $finish;
  end

  initial begin
    seed       = 32'h5bda9e49;
    errorCount = 0;
    checkCount = 0;
    stall          <= 1'b0;
    renameReady    <= 1'b0;
    flagRecoverEX  <= 1'b0;
    ctrlVerified   <= 1'b0;
    ctrlVerifiedId <= '0;
    loadQueueCnt   <= '0;
    storeQueueCnt  <= '0;
    issueQueueCnt  <= '0;
    activeListCnt  <= '0;
    for (int lane = 0; lane < DISPATCH_WIDTH; lane++) begin
      renamedPacket[lane] <= '0;
    end

    resetAndFirstGroup();
    loadStoreCapacity();
    queueCapacity();
    branchMaskClearing();
    blockingInputs();

    $display("Checks: %0d, errors: %0d", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb/clockGen.sv ====
// Testbench clock and reset
// 100 ns clock, active-low reset held for the first 8 rising edges

`timescale 1ns/10ps
`default_nettype none

module clockGen (
  output logic clk_o,
  output logic rstN_o
);

  localparam int HALF_PERIOD  = 50;
  localparam int RESET_CYCLES = 8;

  initial begin
    clk_o = 1'b0;
    forever #(HALF_PERIOD) clk_o = ~clk_o;
  end

  initial begin
    rstN_o <= 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    rstN_o <= 1'b1;                        // Released on an edge like any synchronous input
  end

endmodule

`default_nettype wire

// ==== source/dispatchStage.sv ====
// Dispatch stage top level
// Steers a four-wide renamed group into the back end when every queue has room

`timescale 1ns/10ps
`default_nettype none

module dispatchStage
  import dispatchPkg::*;
(
  input  logic       clk,
  input  logic       rstN_i,
  input  logic       stall_i,              // Back end asks dispatch to hold
  input  logic       renameReady_i,        // Rename offers a full group
  input  logic       flagRecoverEX_i,      // Misprediction recovery in progress
  input  logic       ctrlVerified_i,
  input  ckptIdT     ctrlVerifiedId_i,
  input  renamedPktT renamedPacket_i [DISPATCH_WIDTH],

  input  lsqCntT     loadQueueCnt_i,
  input  lsqCntT     storeQueueCnt_i,
  input  iqCntT      issueQueueCnt_i,
  input  alCntT      activeListCnt_i,

  output renamedPktT issueqPacket_o [DISPATCH_WIDTH],
  output alPktT      alPacket_o [DISPATCH_WIDTH],
  output lsqPktT     lsqPacket_o [DISPATCH_WIDTH],
  output logic       dispatchValid_o,

  // Back to the rename/dispatch pipeline register, so a held group keeps
  // its masks current while it waits
  output ckptMaskT   updatedBranchMask_o [DISPATCH_WIDTH],

  output logic       backEndReady_o,       // Group taken at this edge
  output logic       stallFrontEnd_o       // Some queue lacks room
);

  logic resourceStall;
  logic dispatchGo;

  // Take the group only when rename has one and nothing holds it back
  assign dispatchGo = renameReady_i & ~resourceStall & ~stall_i & ~flagRecoverEX_i;

  assign backEndReady_o  = dispatchGo;
  assign stallFrontEnd_o = resourceStall;

  resourceCheck resourceCheck_inst (
    .renamedPacket_i (renamedPacket_i),
    .loadQueueCnt_i  (loadQueueCnt_i),
    .storeQueueCnt_i (storeQueueCnt_i),
    .issueQueueCnt_i (issueQueueCnt_i),
    .activeListCnt_i (activeListCnt_i),
    .resourceStall_o (resourceStall)
  );

  branchMaskUpdate branchMaskUpdate_inst (
    .renamedPacket_i     (renamedPacket_i),
    .ctrlVerified_i      (ctrlVerified_i),
    .ctrlVerifiedId_i    (ctrlVerifiedId_i),
    .updatedBranchMask_o (updatedBranchMask_o)
  );

  packetFormer packetFormer_inst (
    .clk                 (clk),
    .rstN_i              (rstN_i),
    .dispatchGo_i        (dispatchGo),
    .renamedPacket_i     (renamedPacket_i),
    .updatedBranchMask_i (updatedBranchMask_o),
    .issueqPacket_o      (issueqPacket_o),
    .alPacket_o          (alPacket_o),
    .lsqPacket_o         (lsqPacket_o),
    .dispatchValid_o     (dispatchValid_o)
  );

endmodule

`default_nettype wire

// ==== source/packetFormer.sv ====
// Back-end packet former
// Builds issue-queue, active-list and LSQ packets per lane and registers them
// with a valid flag for the back end

`timescale 1ns/10ps
`default_nettype none

module packetFormer
  import dispatchPkg::*;
(
  input  logic       clk,
  input  logic       rstN_i,
  input  logic       dispatchGo_i,                           // Group taken this cycle
  input  renamedPktT renamedPacket_i [DISPATCH_WIDTH],
  input  ckptMaskT   updatedBranchMask_i [DISPATCH_WIDTH],
  output renamedPktT issueqPacket_o [DISPATCH_WIDTH],
  output alPktT      alPacket_o [DISPATCH_WIDTH],
  output lsqPktT     lsqPacket_o [DISPATCH_WIDTH],
  output logic       dispatchValid_o
);

  renamedPktT issueqNext [DISPATCH_WIDTH];
  alPktT      alNext [DISPATCH_WIDTH];
  lsqPktT     lsqNext [DISPATCH_WIDTH];

  for (genvar lane = 0; lane < DISPATCH_WIDTH; lane++) begin : gLane
    pcT       pc;
    logRegT   logDest;
    physRegT  physDest;
    physRegT  oldPhysDest;
    logic     isLoad;
    logic     isStore;
    logic     destValid;

    // Every lane reads only its own packet
    assign pc          = renamedPacket_i[lane][PC_LSB +: SIZE_PC];
    assign logDest     = renamedPacket_i[lane][LOG_DEST_LSB +: SIZE_RMT_LOG];
    assign physDest    = renamedPacket_i[lane][PHYS_DEST_LSB +: SIZE_PHYSICAL_LOG];
    assign oldPhysDest = renamedPacket_i[lane][OLD_PHYS_LSB +: SIZE_PHYSICAL_LOG];
    assign isLoad      = renamedPacket_i[lane][IS_LOAD_BIT];
    assign isStore     = renamedPacket_i[lane][IS_STORE_BIT];
    assign destValid   = renamedPacket_i[lane][DEST_VALID_BIT];

    // Issue queue keeps the whole packet with the fresh mask spliced in
    assign issueqNext[lane] = {
      renamedPacket_i[lane][RENAMED_W-1:MASK_LSB+CHECKPOINTS],
      updatedBranchMask_i[lane],
      renamedPacket_i[lane][MASK_LSB-1:0]
    };

    assign alNext[lane] = {
      isLoad,
      isStore,
      pc,
      logDest,
      physDest,
      oldPhysDest,       // Freed when this instruction retires
      destValid
    };

    assign lsqNext[lane] = {updatedBranchMask_i[lane], isStore, isLoad};
  end

  // Payload holds its last group until the next one is taken
  always_ff @(posedge clk) begin
    if (dispatchGo_i) begin
      issueqPacket_o <= issueqNext;
      alPacket_o     <= alNext;
      lsqPacket_o    <= lsqNext;
    end
  end

  always_ff @(posedge clk) begin
    if (!rstN_i) begin
      dispatchValid_o <= 1'b0;
    end else begin
      dispatchValid_o <= dispatchGo_i;
    end
  end

  // The back end never sees a group straight out of reset
  assert property (@(posedge clk) !rstN_i |=> !dispatchValid_o)
    else $error("packetFormer: dispatchValid_o high in the cycle after reset");

endmodule

`default_nettype wire

// ==== source/branchMaskUpdate.sv ====
// Branch mask update
// Clears the bit of a just-verified checkpoint in the mask of every lane

`timescale 1ns/10ps
`default_nettype none

module branchMaskUpdate
  import dispatchPkg::*;
(
  input  renamedPktT renamedPacket_i [DISPATCH_WIDTH],
  input  logic       ctrlVerified_i,       // Control instruction resolved correctly
  input  ckptIdT     ctrlVerifiedId_i,     // Its checkpoint
  output ckptMaskT   updatedBranchMask_o [DISPATCH_WIDTH]
);

  ckptMaskT verifiedMask;

  // One-hot on the verified checkpoint, zero when nothing resolved
  assign verifiedMask = ckptMaskT'(ctrlVerified_i) << ctrlVerifiedId_i;

  always_comb begin
    for (int lane = 0; lane < DISPATCH_WIDTH; lane++) begin
      updatedBranchMask_o[lane] =
        renamedPacket_i[lane][MASK_LSB +: CHECKPOINTS] & ~verifiedMask;
    end
  end

endmodule

`default_nettype wire

// ==== source/resourceCheck.sv ====
// Dispatch resource check
// Counts loads and stores in the group and tests every back-end queue for room

`timescale 1ns/10ps
`default_nettype none

module resourceCheck
  import dispatchPkg::*;
(
  input  renamedPktT renamedPacket_i [DISPATCH_WIDTH],
  input  lsqCntT     loadQueueCnt_i,    // Load queue occupancy
  input  lsqCntT     storeQueueCnt_i,   // Store queue occupancy
  input  iqCntT      issueQueueCnt_i,   // Issue queue occupancy
  input  alCntT      activeListCnt_i,   // Active list occupancy
  output logic       resourceStall_o
);

  logic [DISPATCH_WIDTH-1:0] isLoad;
  logic [DISPATCH_WIDTH-1:0] isStore;
  laneCntT                   loadCnt;
  laneCntT                   storeCnt;

  logic loadFull;
  logic storeFull;
  logic issueFull;
  logic activeFull;

  always_comb begin
    loadCnt  = '0;
    storeCnt = '0;
    for (int lane = 0; lane < DISPATCH_WIDTH; lane++) begin
      isLoad[lane]  = renamedPacket_i[lane][IS_LOAD_BIT];
      isStore[lane] = renamedPacket_i[lane][IS_STORE_BIT];
      loadCnt       = loadCnt + laneCntT'(isLoad[lane]);
      storeCnt      = storeCnt + laneCntT'(isStore[lane]);
    end

    // A lane is a load, a store or neither, so the group never asks for more
    // memory entries than it has lanes
    assert (int'(loadCnt) + int'(storeCnt) <= DISPATCH_WIDTH)
      else $error("resourceCheck: %0d loads and %0d stores in one group", loadCnt, storeCnt);
  end

  // Occupancy plus new entries must stay within capacity
  assign loadFull   = (int'(loadQueueCnt_i) + int'(loadCnt)) > SIZE_LSQ;
  assign storeFull  = (int'(storeQueueCnt_i) + int'(storeCnt)) > SIZE_LSQ;
  assign issueFull  = (int'(issueQueueCnt_i) + DISPATCH_WIDTH) > SIZE_ISSUEQ;
  assign activeFull = (int'(activeListCnt_i) + DISPATCH_WIDTH) > SIZE_ACTIVELIST;

  assign resourceStall_o = loadFull | storeFull | issueFull | activeFull;

endmodule

`default_nettype wire

// ==== source/dispatchPkg.sv ====
// Dispatch stage package
// Core sizes, back-end queue capacities, renamed packet layout and vector types

`default_nettype none

package dispatchPkg;

  // Core sizes
  localparam int DISPATCH_WIDTH    = 4;   // Lanes per group
  localparam int CHECKPOINTS       = 4;   // Branch checkpoints
  localparam int CHECKPOINTS_LOG   = 2;
  localparam int SIZE_PC           = 32;
  localparam int SIZE_PHYSICAL_LOG = 6;   // Physical register tag width
  localparam int SIZE_RMT_LOG      = 5;   // Logical register width

  // Back-end queue capacities
  localparam int SIZE_LSQ        = 16;    // Load queue and store queue each
  localparam int SIZE_ISSUEQ     = 32;
  localparam int SIZE_ACTIVELIST = 64;

  // Renamed packet fields, listed from the MSB down as rename packs them.
  // Offsets are built up from the PC, which sits at the bottom.
  localparam int PC_LSB         = 0;
  localparam int DEST_VALID_BIT = PC_LSB + SIZE_PC;
  localparam int SRC2_LSB       = DEST_VALID_BIT + 1;
  localparam int SRC1_LSB       = SRC2_LSB + SIZE_PHYSICAL_LOG;
  localparam int OLD_PHYS_LSB   = SRC1_LSB + SIZE_PHYSICAL_LOG;
  localparam int PHYS_DEST_LSB  = OLD_PHYS_LSB + SIZE_PHYSICAL_LOG;
  localparam int CKPT_ID_LSB    = PHYS_DEST_LSB + SIZE_PHYSICAL_LOG;
  localparam int MASK_LSB       = CKPT_ID_LSB + CHECKPOINTS_LOG;
  localparam int IS_LOAD_BIT    = MASK_LSB + CHECKPOINTS;
  localparam int IS_STORE_BIT   = IS_LOAD_BIT + 1;
  localparam int LOG_DEST_LSB   = IS_STORE_BIT + 1;

  // Packet widths
  localparam int RENAMED_W = LOG_DEST_LSB + SIZE_RMT_LOG;
  localparam int AL_W      = 3 + SIZE_PC + SIZE_RMT_LOG + 2 * SIZE_PHYSICAL_LOG;
  localparam int LSQ_W     = CHECKPOINTS + 2;     // Mask, store flag, load flag

  // Field and count types
  typedef logic [SIZE_PC-1:0]           pcT;
  typedef logic [SIZE_PHYSICAL_LOG-1:0] physRegT;
  typedef logic [SIZE_RMT_LOG-1:0]      logRegT;
  typedef logic [CHECKPOINTS-1:0]       ckptMaskT;
  typedef logic [CHECKPOINTS_LOG-1:0]   ckptIdT;

  // Occupancy counts must also hold the full value
  typedef logic [$clog2(SIZE_LSQ+1)-1:0]        lsqCntT;
  typedef logic [$clog2(SIZE_ISSUEQ+1)-1:0]     iqCntT;
  typedef logic [$clog2(SIZE_ACTIVELIST+1)-1:0] alCntT;
  typedef logic [$clog2(DISPATCH_WIDTH+1)-1:0]  laneCntT;

  // Packets
  typedef logic [RENAMED_W-1:0] renamedPktT;   // Also the issue-queue packet
  typedef logic [AL_W-1:0]      alPktT;
  typedef logic [LSQ_W-1:0]     lsqPktT;

endpackage

`default_nettype wire
